/* filelist.f */
+incdir+include
hdl/besm_bus_pkg.sv
hdl/mmu_cmd_pkg.sv
hdl/mmu_control.sv
hdl/fill_counter.sv
hdl/page_map_ram.sv
hdl/page_status_ram.sv
hdl/mmu_top.sv
sim/tb_mmu.sv

/* Makefile */
# Verilator build and run for the page management unit testbench
# Usage: make [VERILATOR=...] [OBJ_DIR=...] [VFLAGS=...]

VERILATOR  ?= verilator
TOP        ?= tb_mmu
RTL_TOP    ?= mmu_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall --timing

SRCS := $(wildcard hdl/*.sv sim/*.sv include/*.svh)
STIM := sim/mmu_stim.txt

.PHONY: all run build lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build $(STIM)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/mmu_stim.txt */
# op vaddr wdata arb nopg mask | physad map page access reprio done  (all hex, op 7 waits for fill done)
# mask bits 5..0 select physad map page access reprio done; unchecked columns hold 0
1 01400 A8C55 0 0 31 A8C00 A8C55 000 0 0 1
1 0283F 12345 0 0 31 1203F 12345 000 0 0 1
0 017FF 00000 0 0 31 A8FFF A8C55 000 0 0 1
0 0283F 00000 0 1 31 0283F 12345 000 0 0 1
3 01400 A8C00 0 0 39 A8C00 A8C55 2A3 0 0 1
4 01400 00000 0 0 05 00000 00000 000 0 0 1
2 01400 00000 1 0 2D A8C00 00000 2A3 2 0 1
2 01400 00000 3 0 0D 00000 00000 2A3 2 0 1
2 01400 00000 9 0 0D 00000 00000 2A3 2 0 1
2 01400 00000 A 0 0D 00000 00000 2A3 6 0 1
4 01400 00000 0 0 05 00000 00000 000 0 0 1
2 01400 00000 2 0 0D 00000 00000 2A3 6 0 1
4 01400 00000 0 0 05 00000 00000 000 0 0 1
2 01400 00000 4 0 0D 00000 00000 2A3 6 0 1
4 01400 00000 0 0 05 00000 00000 000 0 0 1
2 01400 00000 B 0 0D 00000 00000 2A3 6 0 1
4 01400 00000 0 0 05 00000 00000 000 0 0 1
2 01400 00000 C 0 0D 00000 00000 2A3 6 0 1
3 01400 12000 0 0 09 00000 00000 048 0 0 1
4 01400 00000 0 0 05 00000 00000 000 0 0 1
2 0283F 00000 9 0 2D 1203F 00000 048 2 0 1
4 0283F FFFFC 0 0 05 00000 00000 000 4 0 1
5 0283F 00001 0 0 03 00000 00000 000 0 1 1
3 0283F 18C00 0 0 09 00000 00000 063 0 0 1
5 0283F 00000 0 0 0B 00000 00000 063 0 0 1
3 0283F 19000 0 0 09 00000 00000 064 0 0 1
5 0283F 00000 0 0 0B 00000 00000 064 0 0 1
6 0283F 00000 0 0 0B 00000 00000 064 0 0 0
3 0283F 18C00 0 0 0B 00000 00000 063 0 0 0
5 0283F 00001 0 0 0B 00000 00000 063 0 0 0
6 0283F 00000 0 0 01 00000 00000 000 0 0 0
7 0283F 00000 0 0 0B 00000 00000 063 0 0 1
3 0283F 19000 0 0 0B 00000 00000 064 0 1 1
3 0283F FFC00 0 0 0B 00000 00000 3FF 0 1 1
3 0283F A8C00 0 0 0F 00000 00000 2A3 6 1 1
5 0283F 00000 0 0 0B 00000 00000 2A3 0 0 1

/* sim/tb_mmu.sv */
//----------------------------------------
// Testbench for the page management unit
// Clock, reset, stimulus table read from
// a text file, output checks, watchdog
//----------------------------------------

module tb_mmu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         MAX_LINES    = 256;      // Stimulus table size
    localparam int         CLK_PERIOD   = 8;        // ns
    localparam int         RESET_CYCLES = 5;
    localparam logic [2:0] OP_WAIT_FILL = 3'd7;     // Poll fill done, no command

    //----------------------------------------
    // DUT signals
    //----------------------------------------
    logic                     clk;
    logic                     reset;
    logic                     cmd_valid;
    mmu_cmd_pkg::mmu_cmd_e    cmd;
    besm_bus_pkg::vaddr_t     vaddr;
    besm_bus_pkg::map_entry_t wdata;
    besm_bus_pkg::arb_op_e    arb_op;
    logic                     no_paging;
    besm_bus_pkg::vaddr_t     physad;
    besm_bus_pkg::map_entry_t map_rdata;
    besm_bus_pkg::page_t      page_index;
    logic [2:0]               access;
    logic                     reprio;
    logic                     fill_done;

    //----------------------------------------
    // Stimulus table
    //----------------------------------------
    logic [2:0]  st_op     [MAX_LINES];     // Command or wait marker
    logic [19:0] st_vaddr  [MAX_LINES];
    logic [19:0] st_wdata  [MAX_LINES];
    logic [3:0]  st_arb    [MAX_LINES];
    logic        st_nopg   [MAX_LINES];
    logic [5:0]  st_mask   [MAX_LINES];     // Which outputs to compare
    logic [19:0] st_physad [MAX_LINES];
    logic [19:0] st_map    [MAX_LINES];
    logic [9:0]  st_page   [MAX_LINES];
    logic [2:0]  st_access [MAX_LINES];
    logic        st_reprio [MAX_LINES];
    logic        st_done   [MAX_LINES];
    int          st_src    [MAX_LINES];     // Line number in the file
    int          num_lines;
    int          cur_line;                  // For error lines
    int          budget_ns;                 // Watchdog limit
    logic        loaded;

    mmu_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .i_cmd_valid  (cmd_valid),
        .i_cmd        (cmd),
        .i_vaddr      (vaddr),
        .i_wdata      (wdata),
        .i_arb_op     (arb_op),
        .i_no_paging  (no_paging),
        .o_physad     (physad),
        .o_map_rdata  (map_rdata),
        .o_page_index (page_index),
        .o_access     (access),
        .o_reprio     (reprio),
        .o_fill_done  (fill_done)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;            // 8 ns period

    //----------------------------------------
    // Error handling and checks
    //----------------------------------------
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected %0h actual %0h (stimulus line %0d)",
                     $time, name, expected, actual, cur_line);
            abort_run();
        end
    endtask

    //----------------------------------------
    // Stimulus file
    //----------------------------------------
    task automatic load_stimulus();
        integer      fd;
        string       text;
        int          n;
        int          src_line;
        int          fill_lines;
        int          other_lines;
        logic [31:0] f [12];                        // Raw fields of one line
        fd = $fopen("sim/mmu_stim.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open stimulus file sim/mmu_stim.txt");
            abort_run();
        end
        src_line    = 0;
        fill_lines  = 0;
        other_lines = 0;
        num_lines   = 0;
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            src_line++;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
            if (n == 12 && num_lines < MAX_LINES) begin
                st_op[num_lines]     = f[0][2:0];
                st_vaddr[num_lines]  = f[1][19:0];
                st_wdata[num_lines]  = f[2][19:0];
                st_arb[num_lines]    = f[3][3:0];
                st_nopg[num_lines]   = f[4][0];
                st_mask[num_lines]   = f[5][5:0];
                st_physad[num_lines] = f[6][19:0];
                st_map[num_lines]    = f[7][19:0];
                st_page[num_lines]   = f[8][9:0];
                st_access[num_lines] = f[9][2:0];
                st_reprio[num_lines] = f[10][0];
                st_done[num_lines]   = f[11][0];
                st_src[num_lines]    = src_line;
                if (f[0][2:0] == OP_WAIT_FILL || f[0][2:0] == 3'(mmu_cmd_pkg::CMD_FILL))
                    fill_lines++;                   // Long lines
                else
                    other_lines++;
                num_lines++;
            end else if (n > 0) begin               // Comments and blank lines give none
                $display("error: stimulus line %0d is malformed or the table is full",
                         src_line);
                abort_run();
            end
        end
        $fclose(fd);
        if (num_lines == 0) begin
            $display("error: stimulus file holds no command lines");
            abort_run();
        end
        budget_ns = (1100 * fill_lines + 10 * other_lines + RESET_CYCLES + 10) * CLK_PERIOD;
    endtask

    //----------------------------------------
    // One stimulus line
    //----------------------------------------
    task automatic check_outputs(input int idx);
        logic [5:0] mask;
        mask = st_mask[idx];
        if (mask[5])
            check_value("o_physad", 32'(st_physad[idx]), 32'(physad));
        if (mask[4])
            check_value("o_map_rdata", 32'(st_map[idx]), 32'(map_rdata));
        if (mask[3])
            check_value("o_page_index", 32'(st_page[idx]), 32'(page_index));
        if (mask[2])
            check_value("o_access", 32'(st_access[idx]), 32'(access));
        if (mask[1])
            check_value("o_reprio", 32'(st_reprio[idx]), 32'(reprio));
        if (mask[0])
            check_value("o_fill_done", 32'(st_done[idx]), 32'(fill_done));
    endtask

    task automatic apply_line(input int idx);
        cur_line  = st_src[idx];
        vaddr     = st_vaddr[idx];
        wdata     = st_wdata[idx];
        arb_op    = besm_bus_pkg::arb_op_e'(st_arb[idx]);
        no_paging = st_nopg[idx];
        if (st_op[idx] == OP_WAIT_FILL) begin
            cmd_valid = 1'b0;
            cmd       = mmu_cmd_pkg::CMD_NOP;
            @(posedge clk);
            #1;
            while (fill_done !== 1'b1) begin        // Watchdog catches a hang
                @(posedge clk);
                #1;
            end
        end else begin
            cmd_valid = 1'b1;
            cmd       = mmu_cmd_pkg::mmu_cmd_e'(st_op[idx]);
            @(posedge clk);                         // Command acts here
            #1;
        end
        cmd_valid = 1'b0;
        check_outputs(idx);
    endtask

    //----------------------------------------
    // Main sequence and watchdog
    //----------------------------------------
    initial begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = mmu_cmd_pkg::CMD_NOP;
        vaddr     = '0;
        wdata     = '0;
        arb_op    = besm_bus_pkg::ARB_NOP;
        no_paging = 1'b0;
        cur_line  = 0;
        loaded    = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < num_lines; i++)
            apply_line(i);
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        wait (loaded);
        #(budget_ns);
        $display("error: watchdog expired after %0d ns, a fill never finished", budget_ns);
        abort_run();
    end

endmodule

/* hdl/mmu_top.sv */
//----------------------------------------
// Page management unit top level
// Command decoder, fill counter, page
// map and page status memories
//----------------------------------------

module mmu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_cmd_valid,   // Command strobe
    input  mmu_cmd_pkg::mmu_cmd_e    i_cmd,         // Command opcode
    input  besm_bus_pkg::vaddr_t     i_vaddr,       // Effective address register
    input  besm_bus_pkg::map_entry_t i_wdata,       // Write data word
    input  besm_bus_pkg::arb_op_e    i_arb_op,      // Arbiter opcode
    input  logic                     i_no_paging,   // Translation blocked
    output besm_bus_pkg::vaddr_t     o_physad,      // Translated address
    output besm_bus_pkg::map_entry_t o_map_rdata,   // Map entry of virtual page
    output besm_bus_pkg::page_t      o_page_index,  // Physical page register
    output logic [2:0]               o_access,      // Dirty, used, zero
    output logic                     o_reprio,      // Reprio bit of current page
    output logic                     o_fill_done    // No fill in progress
);

    //----------------------------------------
    // Internal strobes and pages
    //----------------------------------------
    logic                map_we;
    logic                bus_req;
    logic                page_set;
    logic                access_we;
    logic                reprio_we;
    logic                fill_we;
    logic                cnt_load;
    logic                cnt_step;
    logic                cnt_last;
    besm_bus_pkg::page_t fill_page;             // Page under fill
    besm_bus_pkg::page_t phys_page;             // Translated page

    mmu_control u_control (
        .clk         (clk),
        .reset       (reset),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .i_cnt_last  (cnt_last),
        .o_map_we    (map_we),
        .o_bus_req   (bus_req),
        .o_page_set  (page_set),
        .o_access_we (access_we),
        .o_reprio_we (reprio_we),
        .o_fill_we   (fill_we),
        .o_cnt_load  (cnt_load),
        .o_cnt_step  (cnt_step),
        .o_fill_done (o_fill_done)
    );

    fill_counter u_fill_cnt (
        .clk          (clk),
        .reset        (reset),
        .i_load       (cnt_load),
        .i_load_value (o_page_index),           // Fill starts at current page
        .i_step       (cnt_step),
        .o_count      (fill_page),
        .o_last       (cnt_last)
    );

    page_map_ram u_map (
        .clk         (clk),
        .i_we        (map_we),
        .i_vaddr     (i_vaddr),
        .i_wdata     (i_wdata),
        .i_no_paging (i_no_paging),
        .o_rdata     (o_map_rdata),
        .o_phys_page (phys_page),
        .o_physad    (o_physad)
    );

    page_status_ram u_status (
        .clk          (clk),
        .i_bus_req    (bus_req),
        .i_arb_op     (i_arb_op),
        .i_phys_page  (phys_page),
        .i_page_set   (page_set),
        .i_access_we  (access_we),
        .i_reprio_we  (reprio_we),
        .i_wdata      (i_wdata),
        .i_fill_we    (fill_we),
        .i_fill_page  (fill_page),
        .o_page_index (o_page_index),
        .o_access     (o_access),
        .o_reprio     (o_reprio)
    );

endmodule

/* hdl/page_status_ram.sv */
//----------------------------------------
// Page status memories
// Physical page register, per page used,
// dirty and reprioritize bits
//----------------------------------------
`include "mmu_consts.svh"

module page_status_ram (
    input  logic                  clk,
    input  logic                  i_bus_req,     // Bus request
    input  besm_bus_pkg::arb_op_e i_arb_op,      // Arbiter opcode of request
    input  besm_bus_pkg::page_t   i_phys_page,   // Translated page
    input  logic                  i_page_set,    // Page register load
    input  logic                  i_access_we,   // Used/dirty write
    input  logic                  i_reprio_we,   // Reprioritize write
    input  besm_bus_pkg::vaddr_t  i_wdata,       // Write data word
    input  logic                  i_fill_we,     // Fill writes a one
    input  besm_bus_pkg::page_t   i_fill_page,   // Page under fill
    output besm_bus_pkg::page_t   o_page_index,  // Physical page register
    output logic [2:0]            o_access,      // Dirty, used, zero
    output logic                  o_reprio       // Reprio bit of current page
);

    logic pg_used   [`MMU_PAGES];               // Page referenced
    logic pg_dirty  [`MMU_PAGES];               // Page modified
    logic pg_reprio [`MMU_PAGES];               // Reprioritize request
    logic wr_class;                             // Request modifies memory

    //----------------------------------------
    // Write class opcodes
    //----------------------------------------
    always_comb begin
        case (i_arb_op)
            besm_bus_pkg::CCWR,                 // Instruction cache write
            besm_bus_pkg::DCWR,                 // Operand cache write
            besm_bus_pkg::DWR,                  // Result write
            besm_bus_pkg::RDMWR,                // Read-modify-write
            besm_bus_pkg::BTRWR:                // Block transfer write
                wr_class = 1'b1;
            default:
                wr_class = 1'b0;
        endcase
    end

    //----------------------------------------
    // Physical page register
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (i_bus_req)
            o_page_index <= i_phys_page;        // Page of the bus cycle
        else if (i_page_set)
            o_page_index <= i_wdata[`MMU_VADDR_BITS-1:`MMU_OFFSET_BITS];
    end

    //----------------------------------------
    // Used and dirty bits
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (i_bus_req) begin
            pg_used[i_phys_page] <= 1'b1;       // Referenced
            if (wr_class)
                pg_dirty[i_phys_page] <= 1'b1;  // Written
        end else if (i_access_we) begin
            pg_used[o_page_index]  <= i_wdata[1];
            pg_dirty[o_page_index] <= i_wdata[2];
        end
    end

    assign o_access = {pg_dirty[o_page_index], pg_used[o_page_index], 1'b0};

    //----------------------------------------
    // Reprioritize bits
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (i_fill_we)
            pg_reprio[i_fill_page] <= 1'b1;     // Fill sets every bit it passes
        else if (i_reprio_we)
            pg_reprio[o_page_index] <= i_wdata[0];
    end

    assign o_reprio = pg_reprio[o_page_index];

endmodule

/* hdl/page_map_ram.sv */
//----------------------------------------
// Page map memory
// 1024 map entries indexed by virtual page
// and the virtual to physical translation
//----------------------------------------
`include "mmu_consts.svh"

module page_map_ram (
    input  logic                     clk,
    input  logic                     i_we,          // Map write
    input  besm_bus_pkg::vaddr_t     i_vaddr,       // Effective address
    input  besm_bus_pkg::map_entry_t i_wdata,       // New map entry
    input  logic                     i_no_paging,   // Translation blocked
    output besm_bus_pkg::map_entry_t o_rdata,       // Entry of virtual page
    output besm_bus_pkg::page_t      o_phys_page,   // Translated page
    output besm_bus_pkg::vaddr_t     o_physad       // Translated address
);

    besm_bus_pkg::map_entry_t       map_mem [`MMU_PAGES];
    besm_bus_pkg::page_t            vpage;          // Virtual page number
    logic [`MMU_OFFSET_BITS-1:0]    offset;         // Word in page

    assign vpage  = i_vaddr[`MMU_VADDR_BITS-1:`MMU_OFFSET_BITS];
    assign offset = i_vaddr[`MMU_OFFSET_BITS-1:0];

    //----------------------------------------
    // Map write and read
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (i_we)
            map_mem[vpage] <= i_wdata;
    end

    assign o_rdata = map_mem[vpage];            // Asynchronous read

    //----------------------------------------
    // Translation
    //----------------------------------------
    // Physical page sits in the top of the entry; with paging blocked
    // the virtual page is used as is
    always_comb begin
        if (i_no_paging)
            o_phys_page = vpage;
        else
            o_phys_page = o_rdata[`MMU_MAP_BITS-1:`MMU_MAP_BITS-`MMU_PAGE_BITS];
    end

    assign o_physad = {o_phys_page, offset};    // Offset passes through

endmodule

/* hdl/fill_counter.sv */
//----------------------------------------
// Fill page counter
// Loads the start page, counts up and
// flags the last page
//----------------------------------------
`include "mmu_consts.svh"

module fill_counter #(
    parameter int WIDTH = `MMU_PAGE_BITS    // Page number width
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_load,         // Load start page
    input  besm_bus_pkg::page_t i_load_value,   // Start page
    input  logic                i_step,         // Next page
    output besm_bus_pkg::page_t o_count,        // Page written next
    output logic                o_last          // Count is all ones
);

    logic [WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (i_load)
            count <= WIDTH'(i_load_value);      // Fill begins at page register
        else if (i_step)
            count <= count + 1'b1;              // Wraps after last page
    end

    assign o_count = besm_bus_pkg::page_t'(count);
    assign o_last  = &count;                    // Page 1023

endmodule

/* hdl/mmu_control.sv */
//----------------------------------------
// Command decoder and fill sequencer
// Turns the command strobe into write
// strobes and steps the fill counter
//----------------------------------------

module mmu_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_cmd_valid,  // One cycle command strobe
    input  mmu_cmd_pkg::mmu_cmd_e i_cmd,        // Command opcode
    input  logic                  i_cnt_last,   // Fill counter at last page
    output logic                  o_map_we,     // Page map write
    output logic                  o_bus_req,    // Bus request
    output logic                  o_page_set,   // Page register load
    output logic                  o_access_we,  // Used/dirty write
    output logic                  o_reprio_we,  // Reprioritize bit write
    output logic                  o_fill_we,    // Fill writes a one
    output logic                  o_cnt_load,   // Load fill start page
    output logic                  o_cnt_step,   // Advance fill page
    output logic                  o_fill_done   // No fill in progress
);

    mmu_cmd_pkg::fill_state_e state;
    mmu_cmd_pkg::fill_state_e state_next;
    logic                     filling;          // State is FILL_RUN

    assign filling = (state == mmu_cmd_pkg::FILL_RUN);

    //----------------------------------------
    // Command decode
    //----------------------------------------
    always_comb begin
        o_map_we    = 1'b0;
        o_bus_req   = 1'b0;
        o_page_set  = 1'b0;
        o_access_we = 1'b0;
        o_reprio_we = 1'b0;
        o_cnt_load  = 1'b0;
        if (i_cmd_valid) begin
            case (i_cmd)
                mmu_cmd_pkg::CMD_MAP_WR:    o_map_we    = 1'b1;
                mmu_cmd_pkg::CMD_BUS_REQ:   o_bus_req   = 1'b1;
                mmu_cmd_pkg::CMD_PAGE_SET:  o_page_set  = 1'b1;
                mmu_cmd_pkg::CMD_ACCESS_WR: o_access_we = 1'b1;
                mmu_cmd_pkg::CMD_REPRIO_WR: o_reprio_we = !filling;  // Fill owns the bits
                mmu_cmd_pkg::CMD_FILL:      o_cnt_load  = !filling;  // No restart mid fill
                default: ;                                           // NOP
            endcase
        end
    end

    //----------------------------------------
    // Fill sequencer
    //----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            mmu_cmd_pkg::FILL_IDLE:
                if (o_cnt_load)
                    state_next = mmu_cmd_pkg::FILL_RUN;   // Start page loaded this edge
            mmu_cmd_pkg::FILL_RUN:
                if (i_cnt_last)
                    state_next = mmu_cmd_pkg::FILL_IDLE;  // Page 1023 written this edge
            default:
                state_next = mmu_cmd_pkg::FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= mmu_cmd_pkg::FILL_IDLE;
        else
            state <= state_next;
    end

    assign o_fill_we   = filling;               // One bit per cycle
    assign o_cnt_step  = filling;
    assign o_fill_done = !filling;              // Memory full status

endmodule

/* hdl/mmu_cmd_pkg.sv */
//----------------------------------------
// Command side types of the page unit
// Command opcodes and fill states
//----------------------------------------

package mmu_cmd_pkg;

    //----------------------------------------
    // Command opcodes, one per operation
    //----------------------------------------
    typedef enum logic [2:0] {
        CMD_NOP       = 3'd0,           // Nothing
        CMD_MAP_WR    = 3'd1,           // Write page map entry
        CMD_BUS_REQ   = 3'd2,           // Bus request, load page and mark it
        CMD_PAGE_SET  = 3'd3,           // Load page register from data
        CMD_ACCESS_WR = 3'd4,           // Write used and dirty bits
        CMD_REPRIO_WR = 3'd5,           // Write reprioritize bit
        CMD_FILL      = 3'd6            // Start reprioritize fill
    } mmu_cmd_e;

    //----------------------------------------
    // Fill sequencer states
    //----------------------------------------
    typedef enum logic {
        FILL_IDLE = 1'b0,               // No fill, memory full status high
        FILL_RUN  = 1'b1                // Writing ones up to the last page
    } fill_state_e;

endpackage

/* hdl/besm_bus_pkg.sv */
//----------------------------------------
// Bus side types of the page unit
// Arbiter opcodes, page numbers,
// addresses and map words
//----------------------------------------
`include "mmu_consts.svh"

package besm_bus_pkg;

    //----------------------------------------
    // Arbiter opcodes
    //----------------------------------------
    typedef enum logic [3:0] {
        ARB_NOP = 4'd0,                 // No bus cycle
        CCRD    = 4'd1,                 // Instruction cache read
        CCWR    = 4'd2,                 // Instruction cache write
        DCRD    = 4'd3,                 // Operand cache read
        DCWR    = 4'd4,                 // Operand cache write
        DRD     = 4'd9,                 // Direct read
        DWR     = 4'd10,                // Result write
        RDMWR   = 4'd11,                // Read-modify-write
        BTRWR   = 4'd12,                // Block transfer write
        BTRRD   = 4'd13                 // Block transfer read
    } arb_op_e;

    //----------------------------------------
    // Address types
    //----------------------------------------
    typedef logic [`MMU_PAGE_BITS-1:0]  page_t;       // Page number
    typedef logic [`MMU_VADDR_BITS-1:0] vaddr_t;      // Virtual or physical address
    typedef logic [`MMU_MAP_BITS-1:0]   map_entry_t;  // Page map word

endpackage

/* include/mmu_consts.svh */
//----------------------------------------
// Page management unit constants
// Page, offset and address widths,
// map entry width and page count
//----------------------------------------
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// Virtual and physical page number
`define MMU_PAGE_BITS    10

// Word offset inside a page
`define MMU_OFFSET_BITS  10

// Full address, page plus offset
`define MMU_VADDR_BITS   20

// Map entry, physical page in the upper bits
`define MMU_MAP_BITS     20

// Pages covered by the map and the bit arrays
`define MMU_PAGES        1024

`endif
